// ==== Bender.yml ====
package:
  name: fabric_regs

sources:
  - verilog/fabric_bus_pkg.sv
  - verilog/fabric_map_pkg.sv
  - verilog/wb_aperture_decode.sv
  - verilog/fabric_ctrl_regs.sv
  - verilog/reserved_ident_regs.sv
  - verilog/fabric_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_fabric_top.sv

// ==== build.f ====
+incdir+include
verilog/fabric_bus_pkg.sv
verilog/fabric_map_pkg.sv
verilog/wb_aperture_decode.sv
verilog/fabric_ctrl_regs.sv
verilog/reserved_ident_regs.sv
verilog/fabric_top.sv
sim/tb_fabric_top.sv

// ==== include/tb_fabric_tasks.svh ====
// Wishbone host tasks and test sequences, included inside the fabric testbench module
`ifndef TB_FABRIC_TASKS_SVH
`define TB_FABRIC_TASKS_SVH

    // ------------------------------------------------------------------------
    // Bus access
    // ------------------------------------------------------------------------
    // One classic cycle, held through the ack cycle and dropped in the next
    task automatic bus_cycle(input logic we, input logic [16:0] addr, input logic [3:0] lanes,
                             input logic [31:0] wdat, output logic [31:0] rdat,
                             output int latency);
        int cycles;
        @(posedge clk);
        #DRIVE_DELAY;
        wb_req.cyc      = 1'b1;
        wb_req.stb      = 1'b1;
        wb_req.we       = we;
        wb_req.byte_stb = lanes;
        wb_req.adr.raw  = addr;
        wb_req.wdat     = wdat;
        cycles  = 0;
        latency = -1;
        rdat    = '0;
        while (latency < 0 && cycles < ACK_LIMIT)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
            if (wb_rsp.ack)
            begin
                latency = cycles;
                rdat    = wb_rsp.rdat;
            end
        end
        if (latency < 0)
        begin
            $display("No ack within %0d cycles for address 0x%05h", ACK_LIMIT, addr);
            errors++;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic bus_write(input string name, input logic [16:0] addr,
                             input logic [3:0] lanes, input logic [31:0] data,
                             input int exp_latency = MAPPED_LATENCY);
        logic [31:0] ignored;
        int          latency;
        bus_cycle(1'b1, addr, lanes, data, ignored, latency);
        check_latency(name, exp_latency, latency);
    endtask

    task automatic read_expect(input string name, input logic [16:0] addr,
                               input logic [31:0] expected,
                               input int exp_latency = MAPPED_LATENCY);
        logic [31:0] data;
        int          latency;
        bus_cycle(1'b0, addr, 4'hF, 32'h0, data, latency);
        check_latency(name, exp_latency, latency);
        check_word(name, expected, data);
    endtask

    // ------------------------------------------------------------------------
    // Test sequences
    // ------------------------------------------------------------------------
    task automatic test_reset_values();
        begin_test();
        read_expect("device_id_reg", reg_addr(APER_CTRL, REG_DEVICE_ID), 32'(EXP_DEVICE_ID));
        read_expect("scratch_reset", reg_addr(APER_CTRL, REG_SCRATCH), EXP_SCRATCH_RESET);
        read_expect("gpio_out_reset", reg_addr(APER_CTRL, REG_GPIO_OUT), 32'h0);
        read_expect("gpio_oe_reset", reg_addr(APER_CTRL, REG_GPIO_OE), 32'h0);
        read_expect("clk_ctrl_reset", reg_addr(APER_CTRL, REG_CLK_CTRL), 32'h0);
        check_word("gpio_out_pins", 32'h0, 32'(gpio_out));
        check_word("gpio_oe_pins", 32'h0, 32'(gpio_oe));
        check_word("clk_pins", 32'h0, 32'({clk_4m, clk_1m}));
        check_word("device_id_pins", 32'(EXP_DEVICE_ID), 32'(device_id));
        end_test("reset_values");
    endtask

    task automatic test_byte_lanes();
        logic [31:0] data;
        logic [3:0]  lanes;
        int          i;
        begin_test();
        for (i = 0; i < 8; i++)
        begin
            data  = $urandom;
            lanes = 4'($urandom);
            bus_write("scratch_write", reg_addr(APER_CTRL, REG_SCRATCH), lanes, data);
            scratch_model = merge_bytes(scratch_model, data, lanes);
            read_expect("scratch_readback", reg_addr(APER_CTRL, REG_SCRATCH), scratch_model);
        end
        end_test("byte_lanes");
    endtask

    task automatic test_gpio_clocks();
        logic [31:0] data;
        logic [3:0]  lanes;
        int          i;
        begin_test();
        data = $urandom;
        bus_write("gpio_out_write", reg_addr(APER_CTRL, REG_GPIO_OUT), 4'hF, data);
        gpio_out_model = data & GPIO_MASK;
        check_word("gpio_out_pins", gpio_out_model, 32'(gpio_out));
        read_expect("gpio_out_readback", reg_addr(APER_CTRL, REG_GPIO_OUT), gpio_out_model);
        data  = $urandom;
        lanes = 4'($urandom) | 4'b0001;
        bus_write("gpio_oe_write", reg_addr(APER_CTRL, REG_GPIO_OE), lanes, data);
        gpio_oe_model = merge_bytes(gpio_oe_model, data, lanes) & GPIO_MASK;
        check_word("gpio_oe_pins", gpio_oe_model, 32'(gpio_oe));
        read_expect("gpio_oe_readback", reg_addr(APER_CTRL, REG_GPIO_OE), gpio_oe_model);
        // Bit 1 drives the 4 MHz enable, bit 0 the 1 MHz enable
        for (i = 0; i < 4; i++)
        begin
            data  = $urandom;
            lanes = 4'($urandom) | 4'(i % 2);
            bus_write("clk_ctrl_write", reg_addr(APER_CTRL, REG_CLK_CTRL), lanes, data);
            clk_model = merge_bytes(clk_model, data, lanes) & 32'h3;
            check_word("clk_pins", clk_model, 32'({clk_4m, clk_1m}));
            read_expect("clk_ctrl_readback", reg_addr(APER_CTRL, REG_CLK_CTRL), clk_model);
        end
        for (i = 0; i < 3; i++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            gpio_in = GPIO_WIDTH'($urandom);
            repeat (2) @(posedge clk);
            read_expect("gpio_in_sync", reg_addr(APER_CTRL, REG_GPIO_IN), 32'(gpio_in));
        end
        end_test("gpio_clocks");
    endtask

    task automatic test_ident_defaults();
        begin_test();
        read_expect("cust_prod", reg_addr(APER_RESERVED, REG_CUST_PROD), EXP_CUST_PROD);
        read_expect("revisions", reg_addr(APER_RESERVED, REG_REVISIONS), EXP_REVISIONS);
        bus_write("revisions_write", reg_addr(APER_RESERVED, REG_REVISIONS), 4'hF, $urandom);
        read_expect("revisions_kept", reg_addr(APER_RESERVED, REG_REVISIONS), EXP_REVISIONS);
        read_expect("ctrl_hole_low", reg_addr(APER_CTRL, 7'h06), EXP_CTRL_DEF);
        read_expect("ctrl_hole_high", reg_addr(APER_CTRL, 7'h7F), EXP_CTRL_DEF);
        read_expect("reserved_hole_low", reg_addr(APER_RESERVED, 7'h00), EXP_RSV_DEF);
        read_expect("reserved_hole_mid", reg_addr(APER_RESERVED, 7'h41), EXP_RSV_DEF);
        end_test("ident_defaults");
    endtask

    task automatic test_unmapped();
        begin_test();
        read_expect("unmapped_read", reg_addr(6'd5, REG_SCRATCH), EXP_UNMAPPED,
                    UNMAPPED_LATENCY);
        // Same offsets as live control registers, but in a dead aperture
        bus_write("unmapped_write", reg_addr(6'd5, REG_SCRATCH), 4'hF, ~scratch_model,
                  UNMAPPED_LATENCY);
        bus_write("unmapped_gpio_write", reg_addr(6'd5, REG_GPIO_OUT), 4'hF, ~gpio_out_model,
                  UNMAPPED_LATENCY);
        read_expect("scratch_kept", reg_addr(APER_CTRL, REG_SCRATCH), scratch_model);
        read_expect("gpio_out_kept", reg_addr(APER_CTRL, REG_GPIO_OUT), gpio_out_model);
        check_word("gpio_out_pins_kept", gpio_out_model, 32'(gpio_out));
        read_expect("unmapped_top_read", reg_addr(6'd63, 7'h00), EXP_UNMAPPED,
                    UNMAPPED_LATENCY);
        end_test("unmapped");
    endtask

`endif

// ==== sim/tb_fabric_top.sv ====
// Testbench for the register fabric: runs Wishbone cycles against every block and reports
`default_nettype none
`timescale 1ns/1ps

module tb_fabric_top;

    import fabric_bus_pkg::*;
    import fabric_map_pkg::*;

    localparam int GPIO_WIDTH       = 22;
    localparam int TIMEOUT_CYCLES   = 7;
    localparam int CLK_HALF         = 4;
    localparam int CLK_PERIOD       = 2 * CLK_HALF;
    localparam int DRIVE_DELAY      = 1;
    localparam int RESET_CLOCKS     = 4;
    localparam int RANDOM_SEED      = 74136;
    localparam int MAPPED_LATENCY   = 1;
    localparam int UNMAPPED_LATENCY = TIMEOUT_CYCLES + 1;
    localparam int ACK_LIMIT        = 4 * UNMAPPED_LATENCY;

    // Roughly 50 bus cycles in all tests, each at most the timeout plus setup and drop
    localparam int MAX_ACCESSES  = 64;
    localparam int ACCESS_CLOCKS = UNMAPPED_LATENCY + 3;
    localparam int MARGIN_CLOCKS = 200;
    localparam int WATCHDOG_NS   =
        (RESET_CLOCKS + MAX_ACCESSES * ACCESS_CLOCKS + MARGIN_CLOCKS) * CLK_PERIOD;

    // Expected words from the register map
    localparam logic [23:0] EXP_DEVICE_ID     = 24'h00_0A45;
    localparam logic [31:0] EXP_SCRATCH_RESET = 32'h1234_5678;
    localparam logic [31:0] EXP_CUST_PROD     = 32'h0100_0000;
    localparam logic [31:0] EXP_REVISIONS     = 32'h0001_0000;
    localparam logic [31:0] EXP_CTRL_DEF      = 32'hFABD_EFAC;
    localparam logic [31:0] EXP_RSV_DEF       = 32'hDEFF_ABAC;
    localparam logic [31:0] EXP_UNMAPPED      = 32'hBADF_ABAC;
    localparam logic [31:0] GPIO_MASK         = 32'((64'h1 << GPIO_WIDTH) - 1);

    logic                  clk;
    logic                  rst_n;
    wb_req_t               wb_req;
    wb_rsp_t               wb_rsp;
    logic [GPIO_WIDTH-1:0] gpio_in;
    logic [GPIO_WIDTH-1:0] gpio_out;
    logic [GPIO_WIDTH-1:0] gpio_oe;
    logic                  clk_4m;
    logic                  clk_1m;
    logic [23:0]           device_id;

    // Shadow copies of the writable registers
    logic [31:0] scratch_model;
    logic [31:0] gpio_out_model;
    logic [31:0] gpio_oe_model;
    logic [31:0] clk_model;

    int errors;
    int checks;
    int tests_run;
    int err_base;

    always
    begin
        #CLK_HALF;
        clk = ~clk;
    end

    fabric_top #(
        .GPIO_WIDTH     (GPIO_WIDTH),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) fabric_top_inst (
        .wb_clk_i      (clk),
        .rst_n_i       (rst_n),
        .wb_req_i      (wb_req),
        .gpio_in_i     (gpio_in),
        .wb_rsp_o      (wb_rsp),
        .gpio_out_o    (gpio_out),
        .gpio_oe_o     (gpio_oe),
        .clk_4m_cntl_o (clk_4m),
        .clk_1m_cntl_o (clk_1m),
        .device_id_o   (device_id)
    );

    // ------------------------------------------------------------------------
    // Checks and reporting
    // ------------------------------------------------------------------------
    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        checks++;
        assert (actual == expected)
        else
        begin
            $display("Mismatch %s ack latency: expected %0d, actual %0d", name, expected,
                     actual);
            errors++;
        end
    endtask

    task automatic begin_test();
        err_base = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("Test %-16s finished with %0d error(s)", name, errors - err_base);
    endtask

    // Replace the strobed bytes of a word
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  lanes);
        logic [31:0] mask;
        mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // Byte address of a word in an aperture
    function automatic logic [16:0] reg_addr(input logic [5:0] aperture,
                                             input logic [6:0] index);
        return {aperture, 2'b00, index, 2'b00};
    endfunction

    `include "tb_fabric_tasks.svh"

    // Ack must be a single pulse inside an open cycle
    assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb) ##1 !wb_rsp.ack
    )
    else
    begin
        $display("Bus ack was not a single pulse inside an open bus cycle");
        errors++;
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial
    begin
        void'($urandom(RANDOM_SEED));
        clk            = 1'b0;
        rst_n          = 1'b0;
        wb_req         = '0;
        gpio_in        = '0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        err_base       = 0;
        scratch_model  = EXP_SCRATCH_RESET;
        gpio_out_model = '0;
        gpio_oe_model  = '0;
        clk_model      = '0;
        repeat (RESET_CLOCKS) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        test_reset_values();
        test_byte_lanes();
        test_gpio_clocks();
        test_ident_defaults();
        test_unmapped();

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial
    begin
        #WATCHDOG_NS;
        $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/fabric_bus_pkg.sv ====
// Wishbone bus widths and request/response types, imported by every fabric block
`default_nettype none

package fabric_bus_pkg;

    // ------------------------------------------------------------------------
    // Bus geometry
    // ------------------------------------------------------------------------
    localparam int ADDR_WIDTH    = 17;
    localparam int DATA_WIDTH    = 32;
    localparam int STB_WIDTH     = 4;
    // Aperture sits in address bits 16:11
    localparam int APER_WIDTH    = 6;
    // Word index sits in address bits 8:2
    localparam int REG_IDX_WIDTH = 7;

    // Field view of the byte address
    typedef struct packed {
        logic [APER_WIDTH-1:0]    aperture;
        logic [1:0]               unused;
        logic [REG_IDX_WIDTH-1:0] reg_index;
        logic [1:0]               byte_off;
    } fabric_addr_fields_t;

    // Same 17 bits, seen raw or split into fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        fabric_addr_fields_t   fields;
    } fabric_addr_u;

    // ------------------------------------------------------------------------
    // Host to fabric
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [STB_WIDTH-1:0]  byte_stb;
        fabric_addr_u          adr;
        logic [DATA_WIDTH-1:0] wdat;
    } wb_req_t;

    // Fabric to host, rdat valid with ack
    typedef struct packed {
        logic                  ack;
        logic [DATA_WIDTH-1:0] rdat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/fabric_ctrl_regs.sv ====
// General control register block: device ID, clock enables, GPIO and a scratch word
`default_nettype none
`timescale 1ns/1ps

module fabric_ctrl_regs #(
    parameter int GPIO_WIDTH = 22
) (
    input  logic                                       wb_clk_i,
    input  logic                                       rst_n_i,
    input  fabric_bus_pkg::wb_req_t                    req_i,
    input  logic                                       sel_i,
    input  logic [GPIO_WIDTH-1:0]                      gpio_in_i,
    output fabric_bus_pkg::wb_rsp_t                    rsp_o,
    output logic [GPIO_WIDTH-1:0]                      gpio_out_o,
    output logic [GPIO_WIDTH-1:0]                      gpio_oe_o,
    output logic                                       clk_4m_cntl_o,
    output logic                                       clk_1m_cntl_o,
    output logic [fabric_map_pkg::DEVICE_ID_WIDTH-1:0] device_id_o
);

    import fabric_bus_pkg::*;
    import fabric_map_pkg::*;

    logic                  ack_q;
    logic                  wr_en;
    logic [1:0]            clk_ctrl_q;
    logic [GPIO_WIDTH-1:0] gpio_out_q;
    logic [GPIO_WIDTH-1:0] gpio_oe_q;
    logic [DATA_WIDTH-1:0] scratch_q;
    logic [GPIO_WIDTH-1:0] gpio_meta_q;
    logic [GPIO_WIDTH-1:0] gpio_sync_q;
    logic [DATA_WIDTH-1:0] rdat;

    // Replace only the strobed bytes of a word
    function automatic logic [DATA_WIDTH-1:0] lane_merge(
        input logic [DATA_WIDTH-1:0] old_word,
        input logic [DATA_WIDTH-1:0] new_word,
        input logic [STB_WIDTH-1:0]  stb
    );
        logic [DATA_WIDTH-1:0] merged;
        merged = old_word;
        for (int lane = 0; lane < STB_WIDTH; lane++)
        begin
            if (stb[lane])
            begin
                merged[lane*8 +: 8] = new_word[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    // ------------------------------------------------------------------------
    // Bus handshake
    // ------------------------------------------------------------------------
    // Write lands on the same edge that raises ack
    assign wr_en = sel_i && req_i.stb && req_i.we && !ack_q;

    always_ff @(posedge wb_clk_i)
    begin
        if (!rst_n_i)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= sel_i && req_i.stb && !ack_q;
        end
    end

    // ------------------------------------------------------------------------
    // Writable registers
    // ------------------------------------------------------------------------
    always_ff @(posedge wb_clk_i)
    begin
        if (!rst_n_i)
        begin
            clk_ctrl_q <= '0;
            gpio_out_q <= '0;
            gpio_oe_q  <= '0;
            scratch_q  <= SCRATCH_RESET;
        end
        else if (wr_en)
        begin
            case (req_i.adr.fields.reg_index)
                REG_CLK_CTRL:
                begin
                    clk_ctrl_q <= 2'(lane_merge(DATA_WIDTH'(clk_ctrl_q), req_i.wdat,
                                                req_i.byte_stb));
                end
                REG_GPIO_OUT:
                begin
                    gpio_out_q <= GPIO_WIDTH'(lane_merge(DATA_WIDTH'(gpio_out_q),
                                                         req_i.wdat, req_i.byte_stb));
                end
                REG_GPIO_OE:
                begin
                    gpio_oe_q <= GPIO_WIDTH'(lane_merge(DATA_WIDTH'(gpio_oe_q),
                                                        req_i.wdat, req_i.byte_stb));
                end
                REG_SCRATCH:
                begin
                    scratch_q <= lane_merge(scratch_q, req_i.wdat, req_i.byte_stb);
                end
                default:
                begin
                    // ID, GPIO input and holes are read only
                end
            endcase
        end
    end

    // Two-flop synchronizer for the asynchronous pins
    always_ff @(posedge wb_clk_i)
    begin
        gpio_meta_q <= gpio_in_i;
        gpio_sync_q <= gpio_meta_q;
    end

    // ------------------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (req_i.adr.fields.reg_index)
            REG_DEVICE_ID: rdat = DATA_WIDTH'(DEVICE_ID);
            REG_CLK_CTRL:  rdat = DATA_WIDTH'(clk_ctrl_q);
            REG_GPIO_IN:   rdat = DATA_WIDTH'(gpio_sync_q);
            REG_GPIO_OUT:  rdat = DATA_WIDTH'(gpio_out_q);
            REG_GPIO_OE:   rdat = DATA_WIDTH'(gpio_oe_q);
            REG_SCRATCH:   rdat = scratch_q;
            default:       rdat = CTRL_DEF_VALUE;
        endcase
    end

    assign rsp_o = '{ack: ack_q, rdat: rdat};

    assign gpio_out_o    = gpio_out_q;
    assign gpio_oe_o     = gpio_oe_q;
    // Bit 1 enables the 4 MHz clock, bit 0 the 1 MHz clock
    assign clk_4m_cntl_o = clk_ctrl_q[1];
    assign clk_1m_cntl_o = clk_ctrl_q[0];
    assign device_id_o   = DEVICE_ID;

    // Request stays open and addressed the same from acceptance through ack
    assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        rsp_o.ack |-> req_i.stb && $stable(req_i.adr)
    )
    else
    begin
        $error("Control block request changed before its ack");
    end

endmodule

`default_nettype wire

// ==== verilog/fabric_map_pkg.sv ====
// Fabric address map, register indexes, identification constants and default read words
`default_nettype none

package fabric_map_pkg;

    // ------------------------------------------------------------------------
    // Apertures, 2 KB each
    // ------------------------------------------------------------------------
    // Byte 0x00000
    localparam logic [fabric_bus_pkg::APER_WIDTH-1:0] APER_CTRL     = 6'd0;
    // Byte 0x01800
    localparam logic [fabric_bus_pkg::APER_WIDTH-1:0] APER_RESERVED = 6'd3;

    // ------------------------------------------------------------------------
    // Word indexes
    // ------------------------------------------------------------------------
    // General control block
    localparam logic [fabric_bus_pkg::REG_IDX_WIDTH-1:0] REG_DEVICE_ID = 7'h00;
    localparam logic [fabric_bus_pkg::REG_IDX_WIDTH-1:0] REG_CLK_CTRL  = 7'h01;
    localparam logic [fabric_bus_pkg::REG_IDX_WIDTH-1:0] REG_GPIO_IN   = 7'h02;
    localparam logic [fabric_bus_pkg::REG_IDX_WIDTH-1:0] REG_GPIO_OUT  = 7'h03;
    localparam logic [fabric_bus_pkg::REG_IDX_WIDTH-1:0] REG_GPIO_OE   = 7'h04;
    localparam logic [fabric_bus_pkg::REG_IDX_WIDTH-1:0] REG_SCRATCH   = 7'h05;

    // Reserved block, top two words of its aperture
    localparam logic [fabric_bus_pkg::REG_IDX_WIDTH-1:0] REG_CUST_PROD = 7'h7E;
    localparam logic [fabric_bus_pkg::REG_IDX_WIDTH-1:0] REG_REVISIONS = 7'h7F;

    // ------------------------------------------------------------------------
    // Identification and reset values
    // ------------------------------------------------------------------------
    localparam int                         DEVICE_ID_WIDTH = 24;
    localparam logic [DEVICE_ID_WIDTH-1:0] DEVICE_ID       = 24'h00_0A45;

    localparam logic [31:0] SCRATCH_RESET = 32'h1234_5678;

    localparam logic [7:0]  CUSTOMER_ID = 8'h01;
    localparam logic [7:0]  PRODUCT_ID  = 8'h00;
    localparam logic [15:0] MAJOR_REV   = 16'h0001;
    localparam logic [15:0] MINOR_REV   = 16'h0000;

    // ------------------------------------------------------------------------
    // Default read words
    // ------------------------------------------------------------------------
    // Each one tells the host which block missed the access
    localparam logic [31:0] CTRL_DEF_VALUE     = 32'hFABD_EFAC;
    localparam logic [31:0] RESERVED_DEF_VALUE = 32'hDEFF_ABAC;
    localparam logic [31:0] UNMAPPED_VALUE     = 32'hBADF_ABAC;

endpackage

`default_nettype wire

// ==== verilog/fabric_top.sv ====
// Fabric top level: one Wishbone slave port fanned out to the control and reserved blocks
`default_nettype none
`timescale 1ns/1ps

module fabric_top #(
    parameter int GPIO_WIDTH     = 22,
    parameter int TIMEOUT_CYCLES = 7
) (
    input  logic                                       wb_clk_i,
    input  logic                                       rst_n_i,
    input  fabric_bus_pkg::wb_req_t                    wb_req_i,
    input  logic [GPIO_WIDTH-1:0]                      gpio_in_i,
    output fabric_bus_pkg::wb_rsp_t                    wb_rsp_o,
    output logic [GPIO_WIDTH-1:0]                      gpio_out_o,
    output logic [GPIO_WIDTH-1:0]                      gpio_oe_o,
    output logic                                       clk_4m_cntl_o,
    output logic                                       clk_1m_cntl_o,
    output logic [fabric_map_pkg::DEVICE_ID_WIDTH-1:0] device_id_o
);

    import fabric_bus_pkg::*;

    logic    sel_ctrl;
    logic    sel_rsv;
    logic    timeout_ack;
    wb_rsp_t ctrl_rsp;
    wb_rsp_t rsv_rsp;

    // ------------------------------------------------------------------------
    // Decode and response merge
    // ------------------------------------------------------------------------
    wb_aperture_decode wb_aperture_decode_inst (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (wb_req_i),
        .ctrl_rsp_i    (ctrl_rsp),
        .rsv_rsp_i     (rsv_rsp),
        .timeout_ack_i (timeout_ack),
        .sel_ctrl_o    (sel_ctrl),
        .sel_rsv_o     (sel_rsv),
        .bus_rsp_o     (wb_rsp_o)
    );

    // ------------------------------------------------------------------------
    // Register blocks
    // ------------------------------------------------------------------------
    fabric_ctrl_regs #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) fabric_ctrl_regs_inst (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (wb_req_i),
        .sel_i         (sel_ctrl),
        .gpio_in_i     (gpio_in_i),
        .rsp_o         (ctrl_rsp),
        .gpio_out_o    (gpio_out_o),
        .gpio_oe_o     (gpio_oe_o),
        .clk_4m_cntl_o (clk_4m_cntl_o),
        .clk_1m_cntl_o (clk_1m_cntl_o),
        .device_id_o   (device_id_o)
    );

    // Watches the merged bus ack to spot unclaimed cycles
    reserved_ident_regs #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) reserved_ident_regs_inst (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (wb_req_i),
        .sel_i         (sel_rsv),
        .bus_ack_i     (wb_rsp_o.ack),
        .rsp_o         (rsv_rsp),
        .timeout_ack_o (timeout_ack)
    );

endmodule

`default_nettype wire

// ==== verilog/reserved_ident_regs.sv ====
// Identification block: customer, product and revision words plus the bus timeout ack
`default_nettype none
`timescale 1ns/1ps

module reserved_ident_regs #(
    parameter int TIMEOUT_CYCLES = 7
) (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  fabric_bus_pkg::wb_req_t req_i,
    input  logic                    sel_i,
    input  logic                    bus_ack_i,
    output fabric_bus_pkg::wb_rsp_t rsp_o,
    output logic                    timeout_ack_o
);

    import fabric_bus_pkg::*;
    import fabric_map_pkg::*;

    localparam int                  CNT_WIDTH   = $clog2(TIMEOUT_CYCLES + 1);
    localparam logic [CNT_WIDTH-1:0] TIMEOUT_CNT = CNT_WIDTH'(TIMEOUT_CYCLES);

    logic                  ack_q;
    logic                  timeout_q;
    logic                  pending;
    logic [CNT_WIDTH-1:0]  cnt_q;
    logic [DATA_WIDTH-1:0] rdat;

    // ------------------------------------------------------------------------
    // Own aperture, writes acked and dropped
    // ------------------------------------------------------------------------
    always_ff @(posedge wb_clk_i)
    begin
        if (!rst_n_i)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= sel_i && req_i.stb && !ack_q;
        end
    end

    always_comb
    begin
        case (req_i.adr.fields.reg_index)
            REG_CUST_PROD: rdat = {CUSTOMER_ID, PRODUCT_ID, 16'h0000};
            REG_REVISIONS: rdat = {MAJOR_REV, MINOR_REV};
            default:       rdat = RESERVED_DEF_VALUE;
        endcase
    end

    assign rsp_o = '{ack: ack_q, rdat: rdat};

    // ------------------------------------------------------------------------
    // Unclaimed cycle timeout
    // ------------------------------------------------------------------------
    // Open bus cycle that nobody has answered yet
    assign pending = req_i.cyc && req_i.stb && !bus_ack_i && !timeout_q;

    always_ff @(posedge wb_clk_i)
    begin
        if (!rst_n_i)
        begin
            cnt_q     <= '0;
            timeout_q <= 1'b0;
        end
        else if (pending)
        begin
            if (cnt_q == TIMEOUT_CNT)
            begin
                cnt_q     <= '0;
                timeout_q <= 1'b1;
            end
            else
            begin
                cnt_q     <= cnt_q + 1'b1;
                timeout_q <= 1'b0;
            end
        end
        else
        begin
            // Any ack or a dropped strobe restarts the count
            cnt_q     <= '0;
            timeout_q <= 1'b0;
        end
    end

    assign timeout_ack_o = timeout_q;

    // Timeout never lands on a cycle this block answers itself
    assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        timeout_ack_o |-> !rsp_o.ack
    )
    else
    begin
        $error("Timeout ack on a cycle that another block had claimed");
    end

endmodule

`default_nettype wire

// ==== verilog/wb_aperture_decode.sv ====
// Aperture decoder: turns the address into block selects and merges the block responses
`default_nettype none
`timescale 1ns/1ps

module wb_aperture_decode (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  fabric_bus_pkg::wb_req_t req_i,
    input  fabric_bus_pkg::wb_rsp_t ctrl_rsp_i,
    input  fabric_bus_pkg::wb_rsp_t rsv_rsp_i,
    input  logic                    timeout_ack_i,
    output logic                    sel_ctrl_o,
    output logic                    sel_rsv_o,
    output fabric_bus_pkg::wb_rsp_t bus_rsp_o
);

    import fabric_bus_pkg::*;
    import fabric_map_pkg::*;

    logic [APER_WIDTH-1:0] aperture;

    // Field view of the address union
    assign aperture = req_i.adr.fields.aperture;

    // ------------------------------------------------------------------------
    // Block selects
    // ------------------------------------------------------------------------
    // Qualified by cyc only, each block adds stb itself
    assign sel_ctrl_o = req_i.cyc && (aperture == APER_CTRL);
    assign sel_rsv_o  = req_i.cyc && (aperture == APER_RESERVED);

    // ------------------------------------------------------------------------
    // Response merge
    // ------------------------------------------------------------------------
    always_comb
    begin
        // Timeout ack closes cycles to unmapped apertures
        bus_rsp_o.ack = ctrl_rsp_i.ack | rsv_rsp_i.ack | timeout_ack_i;

        case (aperture)
            APER_CTRL:
            begin
                bus_rsp_o.rdat = ctrl_rsp_i.rdat;
            end
            APER_RESERVED:
            begin
                bus_rsp_o.rdat = rsv_rsp_i.rdat;
            end
            default:
            begin
                bus_rsp_o.rdat = UNMAPPED_VALUE;
            end
        endcase
    end

    // Only one source may close a cycle, the timeout included
    assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        $onehot0({ctrl_rsp_i.ack, rsv_rsp_i.ack, timeout_ack_i})
    )
    else
    begin
        $error("More than one ack source active in the same cycle");
    end

endmodule

`default_nettype wire
